//--- build.f
source/lcd_pkg.sv
source/lcd_write_if.sv
source/ms_timer.sv
source/lcd_bus_writer.sv
source/init_rom.sv
source/lcd_sequencer.sv
source/hx8352_top.sv
tb/hx8352_chk.sv
tb/hx8352_tb.sv

//--- Bender.yml
package:
  name: hx8352

sources:
  - files:
      - source/lcd_pkg.sv
      - source/lcd_write_if.sv
      - source/ms_timer.sv
      - source/lcd_bus_writer.sv
      - source/init_rom.sv
      - source/lcd_sequencer.sv
      - source/hx8352_top.sv
  - target: test
    files:
      - tb/hx8352_chk.sv
      - tb/hx8352_tb.sv

//--- tb/hx8352_patterns.txt
# W columns rows | E kind word ms, kind 0 command 1 data 2 delay | F colour colour_after_22
# Words and colours in hex, sizes, kinds and delays in decimal
W 3 2
# Initialization table in order
E 0 0083 0
E 1 0002 0
E 0 0085 0
E 1 0003 0
E 0 003E 0
E 1 00B0 0
E 0 0017 0
E 1 0091 0
E 0 002B 0
E 1 00F9 0
E 2 0000 10
E 0 001B 0
E 1 0014 0
E 0 001A 0
E 1 0011 0
E 2 0000 5
E 0 0024 0
E 1 0038 0
E 2 0000 4
E 0 0024 0
E 1 003C 0
E 0 0016 0
E 0 0001 0
E 1 0006 0
# Frame colour, then the colour applied once 22 is seen
F F800 07E0
F 07E0 001F
F 001F FFFF

//--- tb/hx8352_tb.sv
`default_nettype none

module hx8352_tb;
	localparam int COLUMNS = 3;
	localparam int ROWS    = 2;

	logic            clk = 1'b0;
	logic            rst;
	lcd_pkg::pixel_t color;
	lcd_pkg::pixel_t lcd_data;
	logic            lcd_rs;
	logic            lcd_wr;
	logic            lcd_rd;
	logic            lcd_cs;
	logic            lcd_rst;
	logic            init_done;

	int  cycle = 0;
	int  limit = 0;  // 0 until the patterns are loaded
	int  rel_cycle;
	int  rst_rise_cycle;
	int  last_fall;
	bit  running = 1'b0;
	int  win_cols;
	int  win_rows;

	int              e_kind[$];
	lcd_pkg::pixel_t e_word[$];
	lcd_pkg::ms_t    e_ms[$];
	lcd_pkg::pixel_t f_first[$];
	lcd_pkg::pixel_t f_next[$];

	logic            q_rs[$];  // Captured writes
	lcd_pkg::pixel_t q_word[$];
	int              q_fall[$];
	int              q_rise[$];

	hx8352_top #(.COLUMNS(COLUMNS), .ROWS(ROWS)) DUT (
		.clk       (clk),
		.rst       (rst),
		.color     (color),
		.lcd_data  (lcd_data),
		.lcd_rs    (lcd_rs),
		.lcd_wr    (lcd_wr),
		.lcd_rd    (lcd_rd),
		.lcd_cs    (lcd_cs),
		.lcd_rst   (lcd_rst),
		.init_done (init_done)
	);

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(string name, lcd_pkg::pixel_t got, lcd_pkg::pixel_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_rs(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_ms(string name, lcd_pkg::ms_t ms, int measured);
		if (measured < ms * lcd_pkg::TICKS_PER_MS) begin
			$display("[ERROR] %0t %s got %0d cycles expected at least %0d", $time, name,
				measured, ms * lcd_pkg::TICKS_PER_MS);
			abort_run();
		end
	endtask

	// Cycle count sits on the falling edge so the strobe edges read it stable
	always @(negedge clk) begin
		cycle = cycle + 1;
		if (limit > 0 && cycle > limit) begin
			$display("Timeout: the frames did not finish within %0d cycles", limit);
			abort_run();
		end
		if (DUT.writer_unit.bus_chk.fail_count != 0) begin
			$display("An assertion on the panel bus failed");
			abort_run();
		end
	end

	always @(posedge lcd_rst)
		rst_rise_cycle = cycle;

	always @(negedge lcd_wr) begin
		if (running) begin
			last_fall = cycle;
			if (lcd_cs !== 1'b0 || lcd_rst !== 1'b1) begin
				$display("A write started with lcd_cs high or lcd_rst low");
				abort_run();
			end
			check_rs("lcd_rd", lcd_rd, 1'b1);
		end
	end

	always @(posedge lcd_wr) begin
		if (running) begin
			if (lcd_cs !== 1'b0) begin
				$display("lcd_cs was high when lcd_wr rose");
				abort_run();
			end
			q_rs.push_back(lcd_rs);
			q_word.push_back(lcd_data);
			q_fall.push_back(last_fall);
			q_rise.push_back(cycle);
		end
	end

	// Skips blanks and comment lines and returns the record letter or -1
	task automatic read_tag(input int fd, output int tag);
		int c;
		tag = -1;
		c = $fgetc(fd);
		while (c != -1 && tag == -1) begin
			if (c == "#") begin
				while (c != -1 && c != "\n")
					c = $fgetc(fd);
			end else if (c != " " && c != "\n" && c != "\t" && c != "\r") begin
				tag = c;
			end
			if (tag == -1)
				c = $fgetc(fd);
		end
	endtask

	task automatic load_patterns();
		int              fd;
		int              tag;
		int              code;
		int              k;
		int              m;
		lcd_pkg::pixel_t a;
		lcd_pkg::pixel_t b;
		fd = $fopen("tb/hx8352_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file");
			abort_run();
		end
		read_tag(fd, tag);
		while (tag != -1) begin
			case (tag)
				"W": code = $fscanf(fd, "%d %d", win_cols, win_rows) - 2;
				"E": begin
					code = $fscanf(fd, "%d %h %d", k, a, m) - 3;
					e_kind.push_back(k);
					e_word.push_back(a);
					e_ms.push_back(lcd_pkg::ms_t'(m));
				end
				"F": begin
					code = $fscanf(fd, "%h %h", a, b) - 2;
					f_first.push_back(a);
					f_next.push_back(b);
				end
				default: code = -1;
			endcase
			if (code != 0) begin
				$display("Malformed record in the pattern file");
				abort_run();
			end
			read_tag(fd, tag);
		end
		$fclose(fd);
	endtask

	task automatic next_write(output logic rs, output lcd_pkg::pixel_t word,
		output int fall, output int rise);
		while (q_rs.size() == 0)
			@(negedge clk);
		rs   = q_rs.pop_front();
		word = q_word.pop_front();
		fall = q_fall.pop_front();
		rise = q_rise.pop_front();
	endtask

	// Registers 02 to 09, each command then its value, then 22
	task automatic check_window();
		lcd_pkg::pixel_t col_end;
		lcd_pkg::pixel_t row_end;
		lcd_pkg::pixel_t vals[8];
		logic            rs;
		lcd_pkg::pixel_t word;
		int              fall;
		int              rise;
		col_end = lcd_pkg::pixel_t'(win_cols - 1);
		row_end = lcd_pkg::pixel_t'(win_rows - 1);
		vals = '{16'h0000, 16'h0000, {8'h00, col_end[15:8]}, {8'h00, col_end[7:0]},
			16'h0000, 16'h0000, {8'h00, row_end[15:8]}, {8'h00, row_end[7:0]}};
		for (int r = 0; r < 8; r++) begin
			next_write(rs, word, fall, rise);
			if (init_done !== 1'b1) begin
				$display("init_done is not high during the window setup");
				abort_run();
			end
			check_rs("lcd_rs", rs, 1'b0);
			check_word("lcd_data", word, lcd_pkg::pixel_t'(16'h0002 + r));
			next_write(rs, word, fall, rise);
			check_rs("lcd_rs", rs, 1'b1);
			check_word("lcd_data", word, vals[r]);
		end
		next_write(rs, word, fall, rise);
		check_rs("lcd_rs", rs, 1'b0);
		check_word("lcd_data", word, 16'h0022);
	endtask

	initial begin
		logic            rs;
		lcd_pkg::pixel_t word;
		int              fall;
		int              rise;
		int              prev_rise;
		int              delay_sum;
		int              writes;
		bit              first;
		rst = 1'b1;
		color = '0;
		load_patterns();
		delay_sum = 0;
		writes = 1;  // One extra write closes the last frame
		foreach (e_kind[i]) begin
			if (e_kind[i] == 2)
				delay_sum += e_ms[i];
			else
				writes++;
		end
		writes += f_first.size() * (17 + win_cols * win_rows);
		limit = 8 + (lcd_pkg::RESET_LOW_MS + lcd_pkg::RESET_WAIT_MS + delay_sum)
			* lcd_pkg::TICKS_PER_MS + writes * (lcd_pkg::WR_CYCLES + 4) + 500;

		@(posedge clk);
		color <= f_first[0];
		repeat (7) @(posedge clk);
		rst <= 1'b0;
		rel_cycle = cycle;
		running = 1'b1;

		first = 1'b1;
		delay_sum = 0;
		prev_rise = 0;
		foreach (e_kind[i]) begin
			if (e_kind[i] == 2) begin
				delay_sum += e_ms[i];
			end else begin
				next_write(rs, word, fall, rise);
				if (first) begin
					check_ms("lcd_rst low", lcd_pkg::RESET_LOW_MS, rst_rise_cycle - rel_cycle);
					check_ms("lcd_rst wake", lcd_pkg::RESET_WAIT_MS, fall - rst_rise_cycle);
					first = 1'b0;
				end else if (delay_sum > 0) begin
					check_ms("init delay", lcd_pkg::ms_t'(delay_sum), fall - prev_rise);
				end
				delay_sum = 0;
				check_rs("lcd_rs", rs, e_kind[i] == 1);
				check_word("lcd_data", word, e_word[i]);
				prev_rise = rise;
			end
		end

		foreach (f_first[f]) begin
			check_window();
			@(posedge clk);
			color <= f_next[f];  // Must not show before the next frame
			for (int p = 0; p < win_cols * win_rows; p++) begin
				next_write(rs, word, fall, rise);
				check_rs("lcd_rs", rs, 1'b1);
				check_word("lcd_data", word, f_first[f]);
			end
		end
		// Next window start proves the pixel count
		next_write(rs, word, fall, rise);
		check_rs("lcd_rs", rs, 1'b0);
		check_word("lcd_data", word, 16'h0002);

		if (DUT.writer_unit.bus_chk.fail_count != 0) begin
			$display("An assertion on the panel bus failed");
			abort_run();
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb/hx8352_chk.sv
`default_nettype none

module hx8352_chk (
	input logic            clk,
	input logic            rst,
	input logic            valid,
	input logic            ready,
	input lcd_pkg::pixel_t lcd_data,
	input logic            lcd_rs,
	input logic            lcd_wr
);
	int fail_count = 0;

	// Panel samples on the rise, so the word must hold through it
	a_data_stable: assert property (@(posedge clk) disable iff (rst)
		((!lcd_wr && !$fell(lcd_wr)) || $rose(lcd_wr)) |-> $stable(lcd_data) && $stable(lcd_rs))
		else begin
			$error("lcd_data or lcd_rs changed during the write strobe");
			fail_count++;
		end

	a_wr_low_len: assert property (@(posedge clk) disable iff (rst)
		$fell(lcd_wr) |-> !lcd_wr [*lcd_pkg::WR_LOW_CYCLES] ##1 lcd_wr)
		else begin
			$error("lcd_wr low for the wrong number of cycles");
			fail_count++;
		end

	a_ready_gap: assert property (@(posedge clk) disable iff (rst)
		valid && ready |=> !ready [*lcd_pkg::WR_CYCLES] ##1 ready)
		else begin
			$error("ready gap after acceptance has the wrong length");
			fail_count++;
		end

endmodule

bind lcd_bus_writer hx8352_chk bus_chk (
	.clk      (clk),
	.rst      (rst),
	.valid    (bus.valid),
	.ready    (bus.ready),
	.lcd_data (lcd_data),
	.lcd_rs   (lcd_rs),
	.lcd_wr   (lcd_wr)
);

`default_nettype wire

//--- source/hx8352_top.sv
`default_nettype none

module hx8352_top #(
	parameter int COLUMNS = lcd_pkg::PANEL_COLUMNS,
	parameter int ROWS    = lcd_pkg::PANEL_ROWS
) (
	input  logic            clk,
	input  logic            rst,
	input  lcd_pkg::pixel_t color,
	output lcd_pkg::pixel_t lcd_data,
	output logic            lcd_rs,
	output logic            lcd_wr,
	output logic            lcd_rd,
	output logic            lcd_cs,
	output logic            lcd_rst,
	output logic            init_done
);
	logic                 timer_start;
	lcd_pkg::ms_t         timer_ms;
	logic                 timer_done;
	lcd_pkg::rom_idx_t    rom_idx;
	lcd_pkg::entry_kind_t rom_kind;
	lcd_pkg::pixel_t      rom_word;
	lcd_pkg::ms_t         rom_ms;

	lcd_write_if wr_bus (.clk(clk), .rst(rst));

	ms_timer #(.TICKS_PER_MS(lcd_pkg::TICKS_PER_MS)) timer_unit (
		.clk   (clk),
		.rst   (rst),
		.start (timer_start),
		.ms    (timer_ms),
		.done  (timer_done)
	);

	init_rom rom_unit (
		.idx          (rom_idx),
		.kind         (rom_kind),
		.addr_or_data (rom_word),
		.ms           (rom_ms)
	);

	lcd_sequencer #(.COLUMNS(COLUMNS), .ROWS(ROWS)) seq_unit (
		.clk         (clk),
		.rst         (rst),
		.color       (color),
		.bus         (wr_bus.source),
		.lcd_rst     (lcd_rst),
		.lcd_cs      (lcd_cs),
		.init_done   (init_done),
		.timer_start (timer_start),
		.timer_ms    (timer_ms),
		.timer_done  (timer_done),
		.rom_idx     (rom_idx),
		.rom_kind    (rom_kind),
		.rom_word    (rom_word),
		.rom_ms      (rom_ms)
	);

	lcd_bus_writer writer_unit (
		.clk      (clk),
		.rst      (rst),
		.bus      (wr_bus.sink),
		.lcd_data (lcd_data),
		.lcd_rs   (lcd_rs),
		.lcd_wr   (lcd_wr)
	);

	assign lcd_rd = 1'b1;  // Write only

endmodule

`default_nettype wire

//--- source/lcd_sequencer.sv
`default_nettype none

module lcd_sequencer #(
	parameter int COLUMNS = lcd_pkg::PANEL_COLUMNS,
	parameter int ROWS    = lcd_pkg::PANEL_ROWS
) (
	input  logic                 clk,
	input  logic                 rst,
	input  lcd_pkg::pixel_t      color,
	lcd_write_if.source          bus,
	output logic                 lcd_rst,
	output logic                 lcd_cs,
	output logic                 init_done,
	output logic                 timer_start,
	output lcd_pkg::ms_t         timer_ms,
	input  logic                 timer_done,
	output lcd_pkg::rom_idx_t    rom_idx,
	input  lcd_pkg::entry_kind_t rom_kind,
	input  lcd_pkg::pixel_t      rom_word,
	input  lcd_pkg::ms_t         rom_ms
);
	lcd_pkg::seq_state_t state;
	logic                timer_wait;
	logic                delay_over;
	logic                accept;
	logic                issue;
	logic                nxt_rs;
	lcd_pkg::pixel_t     nxt_word;
	logic [4:0]          win_step;  // 16 window writes then memory write
	logic [$clog2(COLUMNS * ROWS + 1)-1:0] pix_cnt;
	lcd_pkg::pixel_t     frame_color;
	lcd_pkg::pixel_t     col_end;
	lcd_pkg::pixel_t     row_end;
	lcd_pkg::reg_addr_t  win_addr;
	logic [7:0]          win_val;

	assign col_end = lcd_pkg::pixel_t'(COLUMNS - 1);
	assign row_end = lcd_pkg::pixel_t'(ROWS - 1);

	assign accept = bus.valid & bus.ready;
	// done of the timer is stale in the cycle right after start
	assign delay_over = timer_wait & ~timer_start & timer_done;

	always_comb begin
		case (win_step[4:1])
			4'd0:    {win_addr, win_val} = {lcd_pkg::REG_COL_START_H, 8'h00};
			4'd1:    {win_addr, win_val} = {lcd_pkg::REG_COL_START_L, 8'h00};
			4'd2:    {win_addr, win_val} = {lcd_pkg::REG_COL_END_H, col_end[15:8]};
			4'd3:    {win_addr, win_val} = {lcd_pkg::REG_COL_END_L, col_end[7:0]};
			4'd4:    {win_addr, win_val} = {lcd_pkg::REG_ROW_START_H, 8'h00};
			4'd5:    {win_addr, win_val} = {lcd_pkg::REG_ROW_START_L, 8'h00};
			4'd6:    {win_addr, win_val} = {lcd_pkg::REG_ROW_END_H, row_end[15:8]};
			4'd7:    {win_addr, win_val} = {lcd_pkg::REG_ROW_END_L, row_end[7:0]};
			default: {win_addr, win_val} = {lcd_pkg::REG_MEMORY_WRITE, 8'h00};
		endcase
	end

	// Next word offered on the bus
	always_comb begin
		issue    = 1'b0;
		nxt_rs   = 1'b0;
		nxt_word = rom_word;
		case (state)
			lcd_pkg::INIT: begin
				issue  = ~bus.valid & ~timer_wait & (rom_kind != lcd_pkg::DELAY);
				nxt_rs = (rom_kind == lcd_pkg::DATA_WRITE);
			end
			lcd_pkg::WINDOW: begin
				issue    = ~bus.valid;
				nxt_rs   = win_step[0];  // Odd steps carry data
				nxt_word = win_step[0] ? {8'h00, win_val} : {8'h00, win_addr};
			end
			lcd_pkg::PIXELS: begin
				issue    = ~bus.valid;
				nxt_rs   = 1'b1;
				nxt_word = frame_color;
			end
			default: issue = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= lcd_pkg::RESET_LOW;
			lcd_rst     <= 1'b0;
			lcd_cs      <= 1'b1;
			init_done   <= 1'b0;
			bus.valid   <= 1'b0;
			timer_start <= 1'b0;
			timer_ms    <= '0;
			timer_wait  <= 1'b0;
			rom_idx     <= '0;
			win_step    <= '0;
			pix_cnt     <= '0;
		end else begin
			timer_start <= 1'b0;
			if (accept)
				bus.valid <= 1'b0;
			else if (issue)
				bus.valid <= 1'b1;

			case (state)
				lcd_pkg::RESET_LOW: begin
					if (!timer_wait) begin
						timer_start <= 1'b1;
						timer_ms    <= lcd_pkg::RESET_LOW_MS;
						timer_wait  <= 1'b1;
					end else if (delay_over) begin
						timer_wait <= 1'b0;
						lcd_rst    <= 1'b1;
						state      <= lcd_pkg::RESET_WAIT;
					end
				end
				lcd_pkg::RESET_WAIT: begin
					if (!timer_wait) begin
						timer_start <= 1'b1;
						timer_ms    <= lcd_pkg::RESET_WAIT_MS;
						timer_wait  <= 1'b1;
					end else if (delay_over) begin
						timer_wait <= 1'b0;
						lcd_cs     <= 1'b0;  // Selected for good
						rom_idx    <= '0;
						state      <= lcd_pkg::INIT;
					end
				end
				lcd_pkg::INIT: begin
					if (accept || delay_over) begin
						timer_wait <= 1'b0;
						if (rom_idx == lcd_pkg::rom_idx_t'(lcd_pkg::INIT_LEN - 1)) begin
							init_done <= 1'b1;
							win_step  <= '0;
							state     <= lcd_pkg::WINDOW;
						end else begin
							rom_idx <= rom_idx + 1'b1;
						end
					end else if (!timer_wait && !bus.valid && rom_kind == lcd_pkg::DELAY) begin
						timer_start <= 1'b1;
						timer_ms    <= rom_ms;
						timer_wait  <= 1'b1;
					end
				end
				lcd_pkg::WINDOW: begin
					if (accept) begin
						if (win_step == 5'd16) begin
							pix_cnt <= '0;
							state   <= lcd_pkg::PIXELS;
						end else begin
							win_step <= win_step + 1'b1;
						end
					end
				end
				lcd_pkg::PIXELS: begin
					if (accept) begin
						if (pix_cnt == COLUMNS * ROWS - 1) begin
							win_step <= '0;
							state    <= lcd_pkg::WINDOW;
						end else begin
							pix_cnt <= pix_cnt + 1'b1;
						end
					end
				end
				default: state <= lcd_pkg::RESET_LOW;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			bus.rs   <= nxt_rs;
			bus.data <= nxt_word;
		end
		// One colour per frame, taken at the memory write command
		if (state == lcd_pkg::WINDOW && accept && win_step == 5'd16)
			frame_color <= color;
	end

endmodule

`default_nettype wire

//--- source/init_rom.sv
`default_nettype none

module init_rom (
	input  lcd_pkg::rom_idx_t    idx,
	output lcd_pkg::entry_kind_t kind,
	output lcd_pkg::pixel_t      addr_or_data,
	output lcd_pkg::ms_t         ms
);
	logic [25:0] entry;  // Kind, word, delay

	always_comb begin
		case (idx)
			5'd0:  entry = {lcd_pkg::CMD_WRITE,  16'h0083, 8'd0};  // Test mode
			5'd1:  entry = {lcd_pkg::DATA_WRITE, 16'h0002, 8'd0};
			5'd2:  entry = {lcd_pkg::CMD_WRITE,  16'h0085, 8'd0};  // VDC select
			5'd3:  entry = {lcd_pkg::DATA_WRITE, 16'h0003, 8'd0};
			5'd4:  entry = {lcd_pkg::CMD_WRITE,  16'h003E, 8'd0};  // Gamma
			5'd5:  entry = {lcd_pkg::DATA_WRITE, 16'h00B0, 8'd0};
			5'd6:  entry = {lcd_pkg::CMD_WRITE,  16'h0017, 8'd0};  // Power on
			5'd7:  entry = {lcd_pkg::DATA_WRITE, 16'h0091, 8'd0};
			5'd8:  entry = {lcd_pkg::CMD_WRITE,  16'h002B, 8'd0};
			5'd9:  entry = {lcd_pkg::DATA_WRITE, 16'h00F9, 8'd0};
			5'd10: entry = {lcd_pkg::DELAY,      16'h0000, 8'd10};
			5'd11: entry = {lcd_pkg::CMD_WRITE,  16'h001B, 8'd0};  // Power control 3
			5'd12: entry = {lcd_pkg::DATA_WRITE, 16'h0014, 8'd0};
			5'd13: entry = {lcd_pkg::CMD_WRITE,  16'h001A, 8'd0};  // Power control 2
			5'd14: entry = {lcd_pkg::DATA_WRITE, 16'h0011, 8'd0};
			5'd15: entry = {lcd_pkg::DELAY,      16'h0000, 8'd5};
			5'd16: entry = {lcd_pkg::CMD_WRITE,  16'h0024, 8'd0};  // Display control
			5'd17: entry = {lcd_pkg::DATA_WRITE, 16'h0038, 8'd0};
			5'd18: entry = {lcd_pkg::DELAY,      16'h0000, 8'd4};
			5'd19: entry = {lcd_pkg::CMD_WRITE,  16'h0024, 8'd0};
			5'd20: entry = {lcd_pkg::DATA_WRITE, 16'h003C, 8'd0};  // Display on
			5'd21: entry = {lcd_pkg::CMD_WRITE,  16'h0016, 8'd0};  // Memory access
			5'd22: entry = {lcd_pkg::CMD_WRITE,  16'h0001, 8'd0};  // Display mode
			5'd23: entry = {lcd_pkg::DATA_WRITE, 16'h0006, 8'd0};
			default: entry = {lcd_pkg::DELAY,    16'h0000, 8'd0};
		endcase
	end

	assign kind         = lcd_pkg::entry_kind_t'(entry[25:24]);
	assign addr_or_data = entry[23:8];
	assign ms           = entry[7:0];

endmodule

`default_nettype wire

//--- source/lcd_bus_writer.sv
`default_nettype none

module lcd_bus_writer (
	input  logic            clk,
	input  logic            rst,
	lcd_write_if.sink       bus,
	output lcd_pkg::pixel_t lcd_data,
	output logic            lcd_rs,
	output logic            lcd_wr
);
	logic [$clog2(lcd_pkg::WR_CYCLES + 1)-1:0] cnt;
	logic accept;

	assign accept = bus.valid & bus.ready;

	// Strobe shaping and ready gap
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bus.ready <= 1'b1;
			lcd_wr    <= 1'b1;
			cnt       <= '0;
		end else if (accept) begin
			bus.ready <= 1'b0;
			lcd_wr    <= 1'b0;  // Falls with the new word
			cnt       <= '0;
		end else if (!bus.ready) begin
			cnt <= cnt + 1'b1;
			if (cnt == lcd_pkg::WR_LOW_CYCLES - 1)
				lcd_wr <= 1'b1;  // Panel samples on this rise
			if (cnt == lcd_pkg::WR_CYCLES - 1)
				bus.ready <= 1'b1;
		end
	end

	// Held until the next transfer
	always_ff @(posedge clk) begin
		if (accept) begin
			lcd_data <= bus.data;
			lcd_rs   <= bus.rs;
		end
	end

endmodule

`default_nettype wire

//--- source/ms_timer.sv
`default_nettype none

module ms_timer #(
	parameter int TICKS_PER_MS = lcd_pkg::TICKS_PER_MS
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  lcd_pkg::ms_t ms,
	output logic         done
);
	logic [$clog2(TICKS_PER_MS + 1)-1:0] presc;
	lcd_pkg::ms_t count;
	lcd_pkg::ms_t target;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			presc  <= '0;
			count  <= '0;
			target <= '0;
			done   <= 1'b1;  // Idle reads as finished
		end else if (start) begin
			presc  <= '0;
			count  <= '0;
			target <= ms;
			done   <= 1'b0;
		end else if (!done) begin
			if (target == '0) begin
				done <= 1'b1;  // Zero length wait
			end else if (presc == TICKS_PER_MS - 1) begin
				presc <= '0;
				count <= count + 1'b1;
				if (count + 8'd1 == target)
					done <= 1'b1;
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/lcd_write_if.sv
`default_nettype none

interface lcd_write_if (
	input logic clk,
	input logic rst
);
	logic           valid;
	logic           ready;
	logic           rs;    // Low for command, high for data
	lcd_pkg::pixel_t data;

	modport source (input clk, rst, ready, output valid, rs, data);

	modport sink (input clk, rst, valid, rs, data, output ready);

endinterface

`default_nettype wire

//--- source/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	typedef logic [15:0] pixel_t;  // RGB565 colour or bus word
	typedef logic [7:0]  reg_addr_t;
	typedef logic [7:0]  ms_t;
	typedef logic [4:0]  rom_idx_t;

	typedef enum logic [1:0] {
		CMD_WRITE,   // rs low
		DATA_WRITE,  // rs high
		DELAY        // No bus write
	} entry_kind_t;

	typedef enum logic [2:0] {
		RESET_LOW,
		RESET_WAIT,
		INIT,
		WINDOW,
		PIXELS
	} seq_state_t;

	// Cycles per millisecond at simulation scale
	localparam int TICKS_PER_MS = 20;

	localparam ms_t RESET_LOW_MS  = 8'd2;
	localparam ms_t RESET_WAIT_MS = 8'd3;

	localparam int INIT_LEN = 24;

	localparam int WR_LOW_CYCLES = 2;
	localparam int WR_CYCLES     = 4;

	localparam reg_addr_t REG_COL_START_H  = 8'h02;
	localparam reg_addr_t REG_COL_START_L  = 8'h03;
	localparam reg_addr_t REG_COL_END_H    = 8'h04;
	localparam reg_addr_t REG_COL_END_L    = 8'h05;
	localparam reg_addr_t REG_ROW_START_H  = 8'h06;
	localparam reg_addr_t REG_ROW_START_L  = 8'h07;
	localparam reg_addr_t REG_ROW_END_H    = 8'h08;
	localparam reg_addr_t REG_ROW_END_L    = 8'h09;
	localparam reg_addr_t REG_MEMORY_WRITE = 8'h22;

	localparam int PANEL_COLUMNS = 240;
	localparam int PANEL_ROWS    = 400;

endpackage

`default_nettype wire
